//--- src/cipher_pkg.sv
package cipher_pkg;

    // ------------------------------------------------------------------
    // Bus and cipher widths
    // ------------------------------------------------------------------
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int BLOCK_W = 64;
    localparam int KEY_W   = 128;

    // XTEA iteration count, one cycle is two Feistel half-rounds
    localparam int NUM_CYCLES = 32;
    localparam int CNT_W      = 5;

    // Key schedule constant and its 32-fold multiple for decryption
    localparam logic [DATA_W-1:0] XTEA_DELTA   = 32'h9E37_79B9;
    localparam logic [DATA_W-1:0] DEC_SUM_INIT = 32'hC6EF_3720;

    // ------------------------------------------------------------------
    // Register map, byte addresses
    // ------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] REG_CTRL   = 32'h00;
    localparam logic [ADDR_W-1:0] REG_STATUS = 32'h04;
    localparam logic [ADDR_W-1:0] REG_KEY0   = 32'h08;
    localparam logic [ADDR_W-1:0] REG_KEY1   = 32'h0C;
    localparam logic [ADDR_W-1:0] REG_KEY2   = 32'h10;
    localparam logic [ADDR_W-1:0] REG_KEY3   = 32'h14;
    localparam logic [ADDR_W-1:0] REG_DIN0   = 32'h18;
    localparam logic [ADDR_W-1:0] REG_DIN1   = 32'h1C;
    localparam logic [ADDR_W-1:0] REG_DOUT0  = 32'h20;
    localparam logic [ADDR_W-1:0] REG_DOUT1  = 32'h24;
    localparam logic [ADDR_W-1:0] REG_LAST   = 32'h24;

    // AHB word transfer size
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic {
        MODE_ENC = 1'b0,
        MODE_DEC = 1'b1
    } cipher_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_DONE = 2'b10
    } fsm_state_e;

endpackage

//--- src/reg_bus_if.sv
`timescale 1ns/1ns

// Chip-select register bus, bridge side is the master
interface reg_bus_if import cipher_pkg::*; ();

    logic              cs;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    // Combinational read data, valid while cs high and we low
    logic [DATA_W-1:0] rdata;

    modport bridge (
        output cs, we, addr, wdata,
        input  rdata
    );

    modport regs (
        input  cs, we, addr, wdata,
        output rdata
    );

endinterface

//--- src/ahb_reg_bridge.sv
`timescale 1ns/1ns

module ahb_reg_bridge import cipher_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    // AHB-lite slave
    input  logic [ADDR_W-1:0] haddr_i,
    input  logic [DATA_W-1:0] hwdata_i,
    input  logic              hsel_i,
    input  logic              hwrite_i,
    input  logic              hready_i,
    input  logic [1:0]        htrans_i,
    input  logic [2:0]        hsize_i,
    output logic [DATA_W-1:0] hrdata_o,
    output logic              hreadyout_o,
    output logic              hresp_o,
    // Register bus master
    reg_bus_if.bridge         bus
);

    logic              accept;
    logic              addr_ok;
    // Data phase state
    logic              act_q;
    logic              write_q;
    logic              err1_q;
    logic              err2_q;
    logic [ADDR_W-1:0] addr_q;

    // ------------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------------
    // Only NONSEQ and SEQ carry a transfer, bursts treated as singles
    assign accept = hsel_i && hready_i &&
                    (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

    // In range, word aligned, word sized
    assign addr_ok = (haddr_i <= REG_LAST) && (haddr_i[1:0] == 2'b00) &&
                     (hsize_i == HSIZE_WORD);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            act_q   <= 1'b0;
            write_q <= 1'b0;
            err1_q  <= 1'b0;
            err2_q  <= 1'b0;
        end else if (err1_q) begin
            // First error cycle holds hready low, no new address phase
            err1_q <= 1'b0;
            err2_q <= 1'b1;
        end else if (hready_i) begin
            act_q  <= accept && addr_ok;
            err1_q <= accept && !addr_ok;
            err2_q <= 1'b0;
            if (accept) begin
                write_q <= hwrite_i;
            end
        end
    end

    // Latched address
    always_ff @(posedge clk) begin
        if (accept && !err1_q) begin
            addr_q <= haddr_i;
        end
    end

    // ------------------------------------------------------------------
    // Data phase
    // ------------------------------------------------------------------
    // One strobe per transfer, stalled data phase waits for hready
    assign bus.cs    = act_q && hready_i;
    assign bus.we    = write_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = hwdata_i;

    assign hrdata_o    = (act_q && !write_q) ? bus.rdata : '0;
    // Two-cycle ERROR, low then high ready with hresp held
    assign hreadyout_o = !err1_q;
    assign hresp_o     = err1_q || err2_q;

endmodule

//--- src/cipher_regs.sv
`timescale 1ns/1ns

module cipher_regs import cipher_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               done_i,
    input  logic               busy_i,
    input  logic [BLOCK_W-1:0] block_out_i,
    reg_bus_if.regs            bus,
    output logic               start_o,
    output cipher_mode_e       mode_o,
    output logic [KEY_W-1:0]   key_o,
    output logic [BLOCK_W-1:0] block_in_o
);

    logic              wr;
    logic              ctrl_wr;
    logic [DATA_W-1:0] key_q [4];
    logic [DATA_W-1:0] din_q [2];
    cipher_mode_e      mode_q;
    logic              start_q;

    assign wr      = bus.cs && bus.we;
    assign ctrl_wr = wr && (bus.addr == REG_CTRL);

    // Key and input words
    always_ff @(posedge clk) begin
        if (wr) begin
            case (bus.addr)
                REG_KEY0: key_q[0] <= bus.wdata;
                REG_KEY1: key_q[1] <= bus.wdata;
                REG_KEY2: key_q[2] <= bus.wdata;
                REG_KEY3: key_q[3] <= bus.wdata;
                REG_DIN0: din_q[0] <= bus.wdata;
                REG_DIN1: din_q[1] <= bus.wdata;
                default: ;
            endcase
        end
    end

    // Control, bit 0 start pulse, bit 1 mode
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_q <= 1'b0;
            mode_q  <= MODE_ENC;
        end else begin
            start_q <= ctrl_wr && bus.wdata[0];
            if (ctrl_wr) begin
                mode_q <= cipher_mode_e'(bus.wdata[1]);
            end
        end
    end

    assign start_o    = start_q;
    assign mode_o     = mode_q;
    // Word 0 in the low lane, DIN0 is the first half
    assign key_o      = {key_q[3], key_q[2], key_q[1], key_q[0]};
    assign block_in_o = {din_q[0], din_q[1]};

    // Read mux
    always_comb begin
        bus.rdata = '0;
        if (bus.cs && !bus.we) begin
            case (bus.addr)
                REG_CTRL:   bus.rdata = {{(DATA_W-2){1'b0}}, mode_q, 1'b0};
                // Status, bit 0 done, bit 1 busy
                REG_STATUS: bus.rdata = {{(DATA_W-2){1'b0}}, busy_i, done_i};
                REG_KEY0:   bus.rdata = key_q[0];
                REG_KEY1:   bus.rdata = key_q[1];
                REG_KEY2:   bus.rdata = key_q[2];
                REG_KEY3:   bus.rdata = key_q[3];
                REG_DIN0:   bus.rdata = din_q[0];
                REG_DIN1:   bus.rdata = din_q[1];
                REG_DOUT0:  bus.rdata = block_out_i[BLOCK_W-1:DATA_W];
                REG_DOUT1:  bus.rdata = block_out_i[DATA_W-1:0];
                default:    bus.rdata = '0;
            endcase
        end
    end

endmodule

//--- src/cipher_fsm.sv
`timescale 1ns/1ns

module cipher_fsm import cipher_pkg::*; (
    input  logic clk,
    input  logic reset_n,
    input  logic start_i,
    input  logic last_i,
    output logic load_o,
    output logic step_o,
    output logic busy_o,
    output logic done_o
);

    fsm_state_e state_q;
    fsm_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Start from idle or done, start while running is dropped
            ST_IDLE, ST_DONE: if (start_i) state_d = ST_RUN;
            ST_RUN:           if (last_i)  state_d = ST_DONE;
            default:          state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Load also clears the round counter
    assign load_o = start_i && (state_q != ST_RUN);
    assign step_o = (state_q == ST_RUN);
    assign busy_o = (state_q == ST_RUN);
    assign done_o = (state_q == ST_DONE);

endmodule

//--- src/round_counter.sv
`timescale 1ns/1ns

module round_counter import cipher_pkg::*; (
    input  logic clk,
    input  logic reset_n,
    input  logic clear_i,
    input  logic step_i,
    output logic last_o
);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (step_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // High during the step of the final cycle
    assign last_o = step_i && (cnt_q == CNT_W'(NUM_CYCLES - 1));

endmodule

//--- src/xtea_datapath.sv
`timescale 1ns/1ns

module xtea_datapath import cipher_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               load_i,
    input  logic               step_i,
    input  cipher_mode_e       mode_i,
    input  logic [KEY_W-1:0]   key_i,
    input  logic [BLOCK_W-1:0] block_i,
    output logic [BLOCK_W-1:0] block_o
);

    logic [DATA_W-1:0] v0_q, v1_q, sum_q;
    cipher_mode_e      mode_q;
    logic [KEY_W-1:0]  key_q;
    // Next values, forward and inverse
    logic [DATA_W-1:0] sum_e, v0_e, v1_e;
    logic [DATA_W-1:0] sum_d, v0_d, v1_d;

    // Feistel mixing term
    function automatic logic [DATA_W-1:0] mix(input logic [DATA_W-1:0] v);
        return ((v << 4) ^ (v >> 5)) + v;
    endfunction

    function automatic logic [DATA_W-1:0] key_word(input logic [KEY_W-1:0] key,
                                                   input logic [1:0] idx);
        return key[idx*DATA_W +: DATA_W];
    endfunction

    // ------------------------------------------------------------------
    // One full XTEA cycle
    // ------------------------------------------------------------------
    always_comb begin
        // Encrypt, v0 half then v1 half with advanced sum
        sum_e = sum_q + XTEA_DELTA;
        v0_e  = v0_q + (mix(v1_q) ^ (sum_q + key_word(key_q, sum_q[1:0])));
        v1_e  = v1_q + (mix(v0_e) ^ (sum_e + key_word(key_q, sum_e[12:11])));
        // Decrypt, reverse order
        sum_d = sum_q - XTEA_DELTA;
        v1_d  = v1_q - (mix(v0_q) ^ (sum_q + key_word(key_q, sum_q[12:11])));
        v0_d  = v0_q - (mix(v1_d) ^ (sum_d + key_word(key_q, sum_d[1:0])));
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            v0_q   <= '0;
            v1_q   <= '0;
            sum_q  <= '0;
            mode_q <= MODE_ENC;
        end else if (load_i) begin
            v0_q   <= block_i[BLOCK_W-1:DATA_W];
            v1_q   <= block_i[DATA_W-1:0];
            sum_q  <= (mode_i == MODE_DEC) ? DEC_SUM_INIT : '0;
            mode_q <= mode_i;
        end else if (step_i) begin
            if (mode_q == MODE_ENC) begin
                v0_q  <= v0_e;
                v1_q  <= v1_e;
                sum_q <= sum_e;
            end else begin
                v0_q  <= v0_d;
                v1_q  <= v1_d;
                sum_q <= sum_d;
            end
        end
    end

    // Key snapshot at load, register writes mid-run have no effect
    always_ff @(posedge clk) begin
        if (load_i) begin
            key_q <= key_i;
        end
    end

    assign block_o = {v0_q, v1_q};

endmodule

//--- src/cipher_top.sv
`timescale 1ns/1ns

module cipher_top import cipher_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic [ADDR_W-1:0] haddr_i,
    input  logic [DATA_W-1:0] hwdata_i,
    input  logic              hsel_i,
    input  logic              hwrite_i,
    input  logic              hready_i,
    input  logic [1:0]        htrans_i,
    input  logic [2:0]        hsize_i,
    output logic [DATA_W-1:0] hrdata_o,
    output logic              hreadyout_o,
    output logic              hresp_o
);

    // ------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------
    logic               start, done, busy;
    logic               load, step, last;
    cipher_mode_e       mode;
    logic [KEY_W-1:0]   key;
    logic [BLOCK_W-1:0] block_in, block_out;

    reg_bus_if rbus ();

    ahb_reg_bridge u_bridge (
        .clk(clk), .reset_n(reset_n),
        .haddr_i(haddr_i), .hwdata_i(hwdata_i), .hsel_i(hsel_i),
        .hwrite_i(hwrite_i), .hready_i(hready_i), .htrans_i(htrans_i),
        .hsize_i(hsize_i), .hrdata_o(hrdata_o), .hreadyout_o(hreadyout_o),
        .hresp_o(hresp_o), .bus(rbus.bridge)
    );

    cipher_regs u_regs (
        .clk(clk), .reset_n(reset_n), .done_i(done), .busy_i(busy),
        .block_out_i(block_out), .bus(rbus.regs), .start_o(start),
        .mode_o(mode), .key_o(key), .block_in_o(block_in)
    );

    cipher_fsm u_fsm (
        .clk(clk), .reset_n(reset_n), .start_i(start), .last_i(last),
        .load_o(load), .step_o(step), .busy_o(busy), .done_o(done)
    );

    // Load doubles as the counter clear
    round_counter u_cnt (
        .clk(clk), .reset_n(reset_n), .clear_i(load), .step_i(step), .last_o(last)
    );

    xtea_datapath u_dp (
        .clk(clk), .reset_n(reset_n), .load_i(load), .step_i(step),
        .mode_i(mode), .key_i(key), .block_i(block_in), .block_o(block_out)
    );

endmodule

//--- verif/cipher_chk.sv
`timescale 1ns/1ns

module cipher_chk import cipher_pkg::*; (
    input logic       clk,
    input logic       reset_n,
    input logic       hreadyout_i,
    input logic       hresp_i,
    input logic       cs_i,
    input logic       load_i,
    input fsm_state_e state_i,
    input logic       busy_i,
    input logic       done_i
);

    // ------------------------------------------------------------------
    // AHB response
    // ------------------------------------------------------------------
    // First ERROR cycle, ready low, then the second with ready high
    assert property (@(posedge clk) disable iff (!reset_n)
        (hresp_i && !hreadyout_i) |=> (hresp_i && hreadyout_i))
        else $error("ERROR response lacks its second cycle");

    assert property (@(posedge clk) disable iff (!reset_n)
        (hresp_i && hreadyout_i) |-> $past(hresp_i && !hreadyout_i))
        else $error("ERROR response second cycle without a first");

    // No wait states outside an ERROR response
    assert property (@(posedge clk) disable iff (!reset_n)
        !hreadyout_i |-> hresp_i)
        else $error("hreadyout low without hresp");

    assert property (@(posedge clk) disable iff (!reset_n)
        hresp_i |-> !cs_i)
        else $error("register strobe during an ERROR response");

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!reset_n)
        load_i |-> (state_i != ST_RUN))
        else $error("load while the FSM is running");

    assert property (@(posedge clk) disable iff (!reset_n)
        !(busy_i && done_i))
        else $error("busy and done high together");

endmodule

// Bridge instance, FSM inputs tied quiet
bind ahb_reg_bridge cipher_chk bridge_chk (
    .clk(clk), .reset_n(reset_n), .hreadyout_i(hreadyout_o), .hresp_i(hresp_o),
    .cs_i(bus.cs), .load_i(1'b0), .state_i(ST_IDLE), .busy_i(1'b0), .done_i(1'b0)
);

// FSM instance, bus inputs tied quiet
bind cipher_fsm cipher_chk fsm_chk (
    .clk(clk), .reset_n(reset_n), .hreadyout_i(1'b1), .hresp_i(1'b0),
    .cs_i(1'b0), .load_i(load_o), .state_i(state_q), .busy_i(busy_o), .done_i(done_o)
);

//--- verif/tb_cipher.sv
`timescale 1ns/1ns

module tb_cipher import cipher_pkg::*; ();

    // About 20 operations of under 60 cycles plus slack
    localparam int TIMEOUT_CYCLES = 3000;
    // XTEA key schedule constant
    localparam logic [31:0] REF_DELTA = 32'h9E37_79B9;

    logic              clk;
    logic              reset_n;
    logic [ADDR_W-1:0] haddr;
    logic [DATA_W-1:0] hwdata;
    logic              hsel;
    logic              hwrite;
    logic              hready;
    logic [1:0]        htrans;
    logic [2:0]        hsize;
    logic [DATA_W-1:0] hrdata;
    logic              hreadyout;
    logic              hresp;

    string              test_name;
    int                 err_count = 0;
    int                 cycle_cnt = 0;
    // Model of the key and input registers
    logic [KEY_W-1:0]   key_m;
    logic [BLOCK_W-1:0] blk_m;

    // Single slave drives the bus ready
    assign hready = hreadyout;

    cipher_top dut0 (
        .clk(clk), .reset_n(reset_n),
        .haddr_i(haddr), .hwdata_i(hwdata), .hsel_i(hsel), .hwrite_i(hwrite),
        .hready_i(hready), .htrans_i(htrans), .hsize_i(hsize),
        .hrdata_o(hrdata), .hreadyout_o(hreadyout), .hresp_o(hresp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_fail($sformatf("timeout: the run hung after %0d cycles", cycle_cnt));
        end
    end

    // ------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------
    task automatic report_fail(input string msg);
        err_count++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_word(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            report_fail($sformatf("error: %s %s expected %h actual %h",
                                  test_name, what, exp, act));
        end
    endtask

    task automatic check_resp(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            report_fail($sformatf("error: %s %s expected %b actual %b",
                                  test_name, what, exp, act));
        end
    endtask

    task automatic check_mode_block(input string what, input logic [BLOCK_W-1:0] exp,
                                    input logic [BLOCK_W-1:0] act);
        if (act !== exp) begin
            report_fail($sformatf("error: %s %s expected %h actual %h",
                                  test_name, what, exp, act));
        end
    endtask

    // ------------------------------------------------------------------
    // AHB single transfers
    // ------------------------------------------------------------------
    task automatic ahb_xfer(input logic [ADDR_W-1:0] addr, input logic write,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic resp);
        @(negedge clk);
        haddr  = addr;
        hwrite = write;
        hsel   = 1'b1;
        htrans = HTRANS_NONSEQ;
        @(negedge clk);
        // Data phase with the bus idle behind it
        hsel   = 1'b0;
        htrans = HTRANS_IDLE;
        hwdata = wdata;
        // ERROR holds ready low for its first cycle
        while (!hreadyout) begin
            @(negedge clk);
        end
        rdata = hrdata;
        resp  = hresp;
    endtask

    task automatic ahb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic exp_resp);
        logic [DATA_W-1:0] rd;
        logic              resp;
        ahb_xfer(addr, 1'b1, data, rd, resp);
        check_resp($sformatf("hresp of write to %h", addr), exp_resp, resp);
    endtask

    task automatic ahb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            input logic exp_resp);
        logic resp;
        ahb_xfer(addr, 1'b0, '0, data, resp);
        check_resp($sformatf("hresp of read from %h", addr), exp_resp, resp);
    endtask

    // ------------------------------------------------------------------
    // XTEA reference with v0 in the upper half
    // ------------------------------------------------------------------
    function automatic logic [BLOCK_W-1:0] xtea_ref(input cipher_mode_e mode,
                                                    input logic [KEY_W-1:0] key,
                                                    input logic [BLOCK_W-1:0] blk);
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] sum;
        logic [31:0] k [4];
        for (int i = 0; i < 4; i++) begin
            k[i] = key[i*32 +: 32];
        end
        v0 = blk[63:32];
        v1 = blk[31:0];
        if (mode == MODE_ENC) begin
            sum = 32'h0;
            repeat (32) begin
                v0  += (((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]);
                sum += REF_DELTA;
                v1  += (((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]);
            end
        end else begin
            sum = REF_DELTA * 32;
            repeat (32) begin
                v1  -= (((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[sum[12:11]]);
                sum -= REF_DELTA;
                v0  -= (((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum[1:0]]);
            end
        end
        return {v0, v1};
    endfunction

    // ------------------------------------------------------------------
    // Register helpers
    // ------------------------------------------------------------------
    task automatic load_key(input logic [KEY_W-1:0] k);
        key_m = k;
        for (int i = 0; i < 4; i++) begin
            ahb_write(REG_KEY0 + ADDR_W'(4 * i), k[i*DATA_W +: DATA_W], 1'b0);
        end
    endtask

    task automatic load_block(input logic [BLOCK_W-1:0] b);
        blk_m = b;
        ahb_write(REG_DIN0, b[BLOCK_W-1:DATA_W], 1'b0);
        ahb_write(REG_DIN1, b[DATA_W-1:0], 1'b0);
    endtask

    // Key and input words against the model
    task automatic readback_stored();
        logic [DATA_W-1:0] rd;
        for (int i = 0; i < 4; i++) begin
            ahb_read(REG_KEY0 + ADDR_W'(4 * i), rd, 1'b0);
            check_word($sformatf("key word %0d", i), key_m[i*DATA_W +: DATA_W], rd);
        end
        ahb_read(REG_DIN0, rd, 1'b0);
        check_word("input word 0", blk_m[BLOCK_W-1:DATA_W], rd);
        ahb_read(REG_DIN1, rd, 1'b0);
        check_word("input word 1", blk_m[DATA_W-1:0], rd);
    endtask

    // Start in bit 0 and mode in bit 1
    task automatic start_op(input cipher_mode_e mode);
        ahb_write(REG_CTRL, {{(DATA_W-2){1'b0}}, mode, 1'b1}, 1'b0);
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] status;
        status = '0;
        while (!status[0]) begin
            ahb_read(REG_STATUS, status, 1'b0);
        end
    endtask

    task automatic read_result(output logic [BLOCK_W-1:0] b);
        logic [DATA_W-1:0] hi;
        logic [DATA_W-1:0] lo;
        ahb_read(REG_DOUT0, hi, 1'b0);
        ahb_read(REG_DOUT1, lo, 1'b0);
        b = {hi, lo};
    endtask

    task automatic run_and_check(input cipher_mode_e mode, output logic [BLOCK_W-1:0] res);
        logic [BLOCK_W-1:0] exp;
        exp = xtea_ref(mode, key_m, blk_m);
        start_op(mode);
        wait_done();
        read_result(res);
        check_mode_block("result", exp, res);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic reset_readback();
        logic [DATA_W-1:0] rd;
        test_name = "reset_readback";
        ahb_read(REG_STATUS, rd, 1'b0);
        check_word("status after reset", '0, rd);
        load_key({$urandom, $urandom, $urandom, $urandom});
        load_block({$urandom, $urandom});
        readback_stored();
    endtask

    task automatic encrypt_known_answer(output logic [BLOCK_W-1:0] ct,
                                        output logic [BLOCK_W-1:0] pt);
        test_name = "encrypt";
        load_key({$urandom, $urandom, $urandom, $urandom});
        load_block({$urandom, $urandom});
        pt = blk_m;
        run_and_check(MODE_ENC, ct);
    endtask

    // Same key still loaded
    task automatic decrypt_round_trip(input logic [BLOCK_W-1:0] ct,
                                      input logic [BLOCK_W-1:0] pt);
        logic [BLOCK_W-1:0] res;
        test_name = "decrypt";
        load_block(ct);
        run_and_check(MODE_DEC, res);
        check_mode_block("plaintext", pt, res);
    endtask

    task automatic start_while_busy();
        logic [BLOCK_W-1:0] exp;
        logic [BLOCK_W-1:0] res;
        logic [DATA_W-1:0]  rd;
        test_name = "start_busy";
        load_key({$urandom, $urandom, $urandom, $urandom});
        load_block({$urandom, $urandom});
        exp = xtea_ref(MODE_ENC, key_m, blk_m);
        start_op(MODE_ENC);
        ahb_read(REG_STATUS, rd, 1'b0);
        check_word("status while running", 32'h2, rd);
        // New inputs and a second start within the run
        load_key({$urandom, $urandom, $urandom, $urandom});
        load_block({$urandom, $urandom});
        start_op(MODE_DEC);
        wait_done();
        read_result(res);
        check_mode_block("result of first start", exp, res);
    endtask

    task automatic error_response();
        logic [DATA_W-1:0] rd;
        test_name = "error_resp";
        ahb_read(32'h28, rd, 1'b1);
        ahb_write(32'h100, $urandom, 1'b1);
        ahb_read(REG_KEY1 + 32'h1, rd, 1'b1);
        ahb_write(REG_DIN0 + 32'h2, $urandom, 1'b1);
        // Unaligned control write with the start bit must not start a run
        ahb_write(REG_CTRL + 32'h1, 32'h1, 1'b1);
        // Byte-sized write to a valid address
        hsize = 3'b000;
        ahb_write(REG_DIN1, $urandom, 1'b1);
        hsize = HSIZE_WORD;
        readback_stored();
        ahb_read(REG_STATUS, rd, 1'b0);
        check_word("status after errors", 32'h1, rd);
    endtask

    task automatic back_to_back_runs();
        cipher_mode_e       mode;
        logic [BLOCK_W-1:0] res;
        test_name = "back_to_back";
        repeat (4) begin
            mode = cipher_mode_e'($urandom % 2);
            load_key({$urandom, $urandom, $urandom, $urandom});
            load_block({$urandom, $urandom});
            run_and_check(mode, res);
        end
    endtask

    initial begin
        logic [BLOCK_W-1:0] ct;
        logic [BLOCK_W-1:0] pt;
        void'($urandom(84297));
        reset_n = 1'b0;
        haddr   = '0;
        hwdata  = '0;
        hsel    = 1'b0;
        hwrite  = 1'b0;
        htrans  = HTRANS_IDLE;
        hsize   = HSIZE_WORD;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        reset_readback();
        encrypt_known_answer(ct, pt);
        decrypt_round_trip(ct, pt);
        start_while_busy();
        error_response();
        back_to_back_runs();
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- build.f
src/cipher_pkg.sv
src/reg_bus_if.sv
src/ahb_reg_bridge.sv
src/cipher_regs.sv
src/cipher_fsm.sv
src/round_counter.sv
src/xtea_datapath.sv
src/cipher_top.sv
verif/cipher_chk.sv
verif/tb_cipher.sv
